// ==== mfRom.hex ====
// One 32-bit word per line. Words 0-7 are the bank 0 template, 8-15 the bank 1 template.
// Template word is real (upper 16 bits) and imaginary (lower 16 bits); data word is two samples.
// Bank 0
00400000
0030FFF0
0020FFE0
0010FFD0
FFF00010
FFE00020
0008FFF8
00040004
// Bank 1
00050007
FFFB000C
0019FFE7
FF9C0032
0064FFCE
FFE2001E
000FFFF1
FFF80009
// Input data, upper sample first
01000080
FF000040
7FFF8000
00020003
FFFCFFFB
03E8FC18
0010FFF0
12345678
EDCCA988
00000000
00500050
FFB0FFB0
40000001
C000FFFF
0A0BF5F5
7FFF7FFF

// ==== filelist.f ====
+incdir+tb
common/mfConfigPkg.sv
common/mfWordPkg.sv
romPath/sampleRom.sv
romPath/romArbiter.sv
logic/mifStreamer.sv
logic/complexFir.sv
logic/matchedFilterTop.sv
tb/mfTb.sv

// ==== runSim.sh ====
#!/bin/sh
# Build the matched-filter testbench with Verilator, run it and scan the log.
cd "$(dirname "$0")" || exit 1
rm -f build.log sim.log
verilator --binary --timing --assert -Wno-fatal --top-module mfTb -f filelist.f -o mfSim \
	> build.log 2>&1 || { cat build.log; echo "Build failed"; exit 1; }
./obj_dir/mfSim > sim.log 2>&1
cat sim.log
grep -q "\*\*\* TEST FAILED \*\*\*" sim.log && { echo "Simulation failed"; exit 1; }
grep -q "\*\*\* TEST PASSED \*\*\*" sim.log || { echo "Simulation did not finish"; exit 1; }
exit 0

// ==== tb/mfRefModel.svh ====
// Reference model of the matched filter, built from the ROM image and the tap-sum rule.
`ifndef mfRefModelSvh
`define mfRefModelSvh

	// Private copy of the ROM image, read from the same hex file as the ROM.
	logic [2*mfConfigPkg::sampleWidth-1:0] modelRom [mfConfigPkg::romDepth];

	task automatic loadModel();
		$readmemh("mfRom.hex", modelRom);
	endtask

	// One word of the image at a plain integer address.
	function automatic logic [2*mfConfigPkg::sampleWidth-1:0] romWordAt(input int index);
		logic [mfConfigPkg::addrWidth-1:0] addr;
		addr = mfConfigPkg::addrWidth'(index);
		return modelRom[addr];
	endfunction

	// Sample n counts from reset over all streams, and every stream replays the same block.
	// The history before the first sample is zero.
	function automatic longint sampleAt(input int n);
		int pos;
		logic [2*mfConfigPkg::sampleWidth-1:0] w;
		if (n < 0) begin
			return 0;
		end
		pos = n % (2 * mfConfigPkg::dataWords);
		w = romWordAt(int'(mfConfigPkg::dataBase) + pos / 2);
		// The upper half of a data word comes first in time.
		if (pos % 2 == 0) begin
			return longint'($signed(w[31:16]));
		end
		return longint'($signed(w[15:0]));
	endfunction

	// Coefficient of tap k in a bank, real or imaginary part.
	function automatic longint coeffAt(input logic bank, input int k, input logic imag);
		int base;
		logic [2*mfConfigPkg::sampleWidth-1:0] w;
		base = bank ? int'(mfConfigPkg::bankBase1) : int'(mfConfigPkg::bankBase0);
		w = romWordAt(base + k);
		if (imag) begin
			return longint'($signed(w[15:0]));
		end
		return longint'($signed(w[31:16]));
	endfunction

	// Output n is the sum over taps of coefficient k times the sample k places earlier.
	function automatic longint expectedSum(input int n, input logic bank, input logic imag);
		longint sum;
		sum = 0;
		for (int k = 0; k < mfConfigPkg::tapCount; k++) begin
			sum += coeffAt(bank, k, imag) * sampleAt(n - k);
		end
		return sum;
	endfunction

`endif

// ==== tb/mfTb.sv ====
// Testbench for the matched-filter front end, checking outputs against a reference model.
`timescale 1ns/1ps
`default_nettype none

module mfTb;

	localparam time clockPeriod = 10ns;
	localparam time driveDelay = 1ns;
	localparam int resetCycles = 16;
	localparam int randomSeed = 59;
	localparam int streamSamples = 2 * mfConfigPkg::dataWords;
	localparam int totalSamples = 2 * streamSamples;
	localparam int totalLoads = 2;
	localparam int timeoutCycles = 20 * (totalSamples + totalLoads) * 10;
	// Long enough for a wrongly accepted restart to show its first outputs.
	localparam int quietCycles = 2 * mfConfigPkg::tapCount;

	logic clock;
	logic rst;
	logic loadCoeff;
	logic bankSel;
	logic startData;
	logic filtStrobe;
	logic signed [mfConfigPkg::accWidth-1:0] filtRe;
	logic signed [mfConfigPkg::accWidth-1:0] filtIm;
	logic filtBank;
	logic coeffSetFlag;
	logic dataDoneFlag;

	// Counts kept by the monitor, and the stream bookkeeping kept by the stimulus.
	int outCount;
	int sampleCount;
	int outBase;
	int sampleBase;
	int streamIndex;
	int bankChanges;
	int contentionCycles;
	logic lastBank;
	logic seenCoeffSet;
	logic prevDone;
	// Bit 0 holds the sample strobe of one cycle ago, bit 1 that of two cycles ago.
	logic [1:0] strobeHistory;

	`include "mfRefModel.svh"

	matchedFilterTop i_dut (
		.clock(clock), .rst(rst),
		.loadCoeff(loadCoeff), .bankSel(bankSel), .startData(startData),
		.filtStrobe(filtStrobe), .filtRe(filtRe), .filtIm(filtIm), .filtBank(filtBank),
		.coeffSetFlag(coeffSetFlag), .dataDoneFlag(dataDoneFlag)
	);

	initial begin
		clock = 1'b0;
		forever begin
			#(clockPeriod / 2) clock = ~clock;
		end
	end

	task automatic reportMismatch(input string testName, input longint expected,
			input longint actual);
		$display("Fail %s expected %0d actual %0d", testName, expected, actual);
		$display("*** TEST FAILED ***");
		$fatal(1, "Stopped at the first error.");
	endtask

	task automatic reportFault(input string what);
		$display("Error: %s", what);
		$display("*** TEST FAILED ***");
		$fatal(1, "Stopped at the first error.");
	endtask

	task automatic waitCycles(input int n);
		repeat (n) @(posedge clock);
	endtask

	// bankSel stays where it is after the pulse, since the FIR tags each coefficient with it.
	task automatic startLoad(input logic bank);
		@(posedge clock);
		#(driveDelay);
		bankSel = bank;
		loadCoeff = 1'b1;
		@(posedge clock);
		#(driveDelay);
		loadCoeff = 1'b0;
	endtask

	task automatic pulseStart();
		@(posedge clock);
		#(driveDelay);
		startData = 1'b1;
		@(posedge clock);
		#(driveDelay);
		startData = 1'b0;
	endtask

	// Outputs are registered on the rising edge, so the falling edge sees them settled.
	always @(negedge clock) begin : outputMonitor
		longint expRe;
		longint expIm;
		if (rst) begin
			strobeHistory = 2'b00;
			prevDone = 1'b0;
		end else begin
			// An output follows its sample by exactly two cycles.
			assert (filtStrobe == strobeHistory[1])
				else reportMismatch("strobeLatency", longint'(strobeHistory[1]),
					longint'(filtStrobe));
			strobeHistory = {strobeHistory[0], i_dut.sampleStrobe};
			// The done flag may only rise once the whole block has been sent.
			if (dataDoneFlag && !prevDone) begin
				assert (sampleCount - sampleBase == streamSamples)
					else reportMismatch("dataDoneSamples", longint'(streamSamples),
						longint'(sampleCount - sampleBase));
			end
			prevDone = dataDoneFlag;
			if (i_dut.sampleStrobe) begin
				sampleCount++;
			end
			if (seenCoeffSet) begin
				assert (coeffSetFlag) else reportFault("coeffSetFlag dropped after a load");
			end
			seenCoeffSet = seenCoeffSet | coeffSetFlag;
			if (i_dut.coeffReq && i_dut.dataReq) begin
				contentionCycles++;
			end
			if (filtStrobe) begin
				expRe = expectedSum(outCount, filtBank, 1'b0);
				expIm = expectedSum(outCount, filtBank, 1'b1);
				assert (longint'(filtRe) == expRe)
					else reportMismatch($sformatf("stream%0d filtRe out%0d", streamIndex,
						outCount), expRe, longint'(filtRe));
				assert (longint'(filtIm) == expIm)
					else reportMismatch($sformatf("stream%0d filtIm out%0d", streamIndex,
						outCount), expIm, longint'(filtIm));
				// Only bank 0 has been loaded while the first stream runs.
				if (streamIndex == 1) begin
					assert (!filtBank) else reportMismatch("stream1 filtBank", 0,
						longint'(filtBank));
				end
				// One switch from 0 to 1, and never back.
				if (filtBank != lastBank) begin
					bankChanges++;
					assert (filtBank && streamIndex == 2 && bankChanges == 1)
						else reportMismatch("bankOrder", longint'(lastBank),
							longint'(filtBank));
				end
				lastBank = filtBank;
				outCount++;
			end
		end
	end

	initial begin
		int gap;
		int loadAfter;
		void'($urandom(randomSeed));
		rst = 1'b1;
		loadCoeff = 1'b0;
		bankSel = 1'b0;
		startData = 1'b0;
		outCount = 0;
		sampleCount = 0;
		outBase = 0;
		sampleBase = 0;
		streamIndex = 0;
		bankChanges = 0;
		contentionCycles = 0;
		lastBank = 1'b0;
		seenCoeffSet = 1'b0;
		loadModel();
		repeat (resetCycles) @(posedge clock);
		#(driveDelay);
		rst = 1'b0;

		// Quiet outputs and low flags straight after reset, and still before the first load.
		@(negedge clock);
		assert (!filtStrobe) else reportMismatch("resetFiltStrobe", 0, longint'(filtStrobe));
		assert (!coeffSetFlag) else reportMismatch("resetCoeffSet", 0, longint'(coeffSetFlag));
		assert (!dataDoneFlag) else reportMismatch("resetDataDone", 0, longint'(dataDoneFlag));
		gap = 2 + int'($urandom % 8);
		waitCycles(gap);
		assert (!coeffSetFlag) else reportMismatch("idleCoeffSet", 0, longint'(coeffSetFlag));

		// Bank 0 template, then the first stream on it.
		startLoad(1'b0);
		wait (coeffSetFlag === 1'b1);
		gap = 1 + int'($urandom % 8);
		waitCycles(gap);
		assert (!dataDoneFlag) else reportMismatch("idleDataDone", 0, longint'(dataDoneFlag));
		streamIndex = 1;
		outBase = outCount;
		sampleBase = sampleCount;
		pulseStart();
		wait (dataDoneFlag === 1'b1);
		wait (outCount - outBase == streamSamples);
		waitCycles(quietCycles);
		assert (outCount - outBase == streamSamples)
			else reportMismatch("stream1Outputs", longint'(streamSamples),
				longint'(outCount - outBase));

		// Second stream, with a bank 1 load and a stray start landing while it runs.
		streamIndex = 2;
		outBase = outCount;
		sampleBase = sampleCount;
		pulseStart();
		loadAfter = 4 + int'($urandom % 8);
		wait (sampleCount - sampleBase >= loadAfter);
		startLoad(1'b1);
		gap = 1 + int'($urandom % 4);
		waitCycles(gap);
		pulseStart();
		@(posedge i_dut.loadDone);
		assert (!dataDoneFlag) else reportFault("bank 1 load finished after the stream");
		wait (dataDoneFlag === 1'b1);
		wait (outCount - outBase == streamSamples);
		waitCycles(quietCycles);
		assert (outCount - outBase == streamSamples)
			else reportMismatch("stream2Outputs", longint'(streamSamples),
				longint'(outCount - outBase));
		assert (contentionCycles > 0) else reportFault("the two streamers never met at the ROM");
		assert (lastBank) else reportMismatch("stream2FinalBank", 1, longint'(lastBank));

		$display("*** TEST PASSED ***");
		$finish;
	end

	// Ends a run that stops making progress.
	initial begin
		repeat (timeoutCycles) @(posedge clock);
		reportFault($sformatf("watchdog timeout after %0d cycles", timeoutCycles));
	end

endmodule

`default_nettype wire

// ==== logic/matchedFilterTop.sv ====
// Matched-filter top level joining the shared ROM, its arbiter, two streamers and the FIR.
`timescale 1ns/1ps
`default_nettype none

module matchedFilterTop (
	input wire logic clock,
	input wire logic rst,
	input wire logic loadCoeff,
	input wire logic bankSel,
	input wire logic startData,
	output logic filtStrobe,
	output logic signed [mfConfigPkg::accWidth-1:0] filtRe,
	output logic signed [mfConfigPkg::accWidth-1:0] filtIm,
	output logic filtBank,
	output logic coeffSetFlag,
	output logic dataDoneFlag
);

	// Coefficient streamer side of the arbiter.
	logic coeffReq;
	logic coeffGrant;
	logic [mfConfigPkg::addrWidth-1:0] coeffAddr;

	// Data streamer side of the arbiter.
	logic dataReq;
	logic dataGrant;
	logic [mfConfigPkg::addrWidth-1:0] dataAddr;

	logic [mfConfigPkg::addrWidth-1:0] romAddr;
	mfWordPkg::romWord_t romData;

	logic coeffStrobe;
	logic signed [mfConfigPkg::sampleWidth-1:0] coeffRe;
	logic signed [mfConfigPkg::sampleWidth-1:0] coeffIm;
	logic loadDone;
	logic sampleStrobe;
	logic signed [mfConfigPkg::sampleWidth-1:0] sampleIn;

	sampleRom i_rom (.clock(clock), .addr(romAddr), .data(romData));

	// Template loads sit on port A, the data stream on port B.
	romArbiter i_arbiter (
		.clock(clock), .rst(rst),
		.reqA(coeffReq), .reqB(dataReq),
		.addrA(coeffAddr), .addrB(dataAddr),
		.grantA(coeffGrant), .grantB(dataGrant),
		.romAddr(romAddr)
	);

	mifStreamer #(.mode(mfWordPkg::modeCoeff)) coeffStreamer (
		.clock(clock), .rst(rst), .start(loadCoeff), .bankSel(bankSel),
		.romReq(coeffReq), .romAddr(coeffAddr), .romGrant(coeffGrant), .romData(romData),
		.outStrobe(coeffStrobe), .outRe(coeffRe), .outIm(coeffIm), .done(loadDone)
	);

	// Data samples are real, so the imaginary output is left open.
	mifStreamer #(.mode(mfWordPkg::modeData)) dataStreamer (
		.clock(clock), .rst(rst), .start(startData), .bankSel(1'b0),
		.romReq(dataReq), .romAddr(dataAddr), .romGrant(dataGrant), .romData(romData),
		.outStrobe(sampleStrobe), .outRe(sampleIn), .outIm(), .done(dataDoneFlag)
	);

	// The bank tag is taken from bankSel with each coefficient.
	// bankSel is expected to hold steady for the whole load.
	complexFir i_fir (
		.clock(clock), .rst(rst),
		.coeffStrobe(coeffStrobe), .coeffRe(coeffRe), .coeffIm(coeffIm),
		.loadBank(bankSel), .loadDone(loadDone),
		.sampleStrobe(sampleStrobe), .sampleIn(sampleIn),
		.filtStrobe(filtStrobe), .filtRe(filtRe), .filtIm(filtIm), .filtBank(filtBank),
		.coeffSetFlag(coeffSetFlag)
	);

endmodule

`default_nettype wire

// ==== logic/complexFir.sv ====
// Double-buffered complex-coefficient FIR that correlates real samples against a template.
`timescale 1ns/1ps
`default_nettype none

module complexFir (
	input wire logic clock,
	input wire logic rst,
	input wire logic coeffStrobe,
	input wire logic signed [mfConfigPkg::sampleWidth-1:0] coeffRe,
	input wire logic signed [mfConfigPkg::sampleWidth-1:0] coeffIm,
	input wire logic loadBank,
	input wire logic loadDone,
	input wire logic sampleStrobe,
	input wire logic signed [mfConfigPkg::sampleWidth-1:0] sampleIn,
	output logic filtStrobe,
	output logic signed [mfConfigPkg::accWidth-1:0] filtRe,
	output logic signed [mfConfigPkg::accWidth-1:0] filtIm,
	output logic filtBank,
	output logic coeffSetFlag
);

	// Template being loaded, and the bank it came from.
	logic signed [mfConfigPkg::sampleWidth-1:0] shadowRe [mfConfigPkg::tapCount];
	logic signed [mfConfigPkg::sampleWidth-1:0] shadowIm [mfConfigPkg::tapCount];
	logic shadowBank;

	// Template in use by the datapath.
	logic signed [mfConfigPkg::sampleWidth-1:0] activeRe [mfConfigPkg::tapCount];
	logic signed [mfConfigPkg::sampleWidth-1:0] activeIm [mfConfigPkg::tapCount];
	logic activeBank;

	// Coefficients that the current sample is multiplied with.
	logic signed [mfConfigPkg::sampleWidth-1:0] useRe [mfConfigPkg::tapCount];
	logic signed [mfConfigPkg::sampleWidth-1:0] useIm [mfConfigPkg::tapCount];
	logic useBank;

	// The window is the new sample plus the history of the seven before it.
	logic signed [mfConfigPkg::sampleWidth-1:0] delayLine [mfConfigPkg::tapCount-1];
	logic signed [mfConfigPkg::sampleWidth-1:0] window [mfConfigPkg::tapCount];

	// Product stage.
	logic signed [2*mfConfigPkg::sampleWidth-1:0] prodRe [mfConfigPkg::tapCount];
	logic signed [2*mfConfigPkg::sampleWidth-1:0] prodIm [mfConfigPkg::tapCount];
	logic prodValid;
	logic prodBank;

	logic signed [mfConfigPkg::accWidth-1:0] sumRe;
	logic signed [mfConfigPkg::accWidth-1:0] sumIm;

	// Words arrive in address order.
	// So after a full load, word k sits at tap k.
	always_ff @(posedge clock) begin
		if (coeffStrobe) begin
			for (int k = 0; k < mfConfigPkg::tapCount - 1; k++) begin
				shadowRe[k] <= shadowRe[k+1];
				shadowIm[k] <= shadowIm[k+1];
			end
			shadowRe[mfConfigPkg::tapCount-1] <= coeffRe;
			shadowIm[mfConfigPkg::tapCount-1] <= coeffIm;
			shadowBank <= loadBank;
		end
	end

	// Swap the finished template in.
	// The flag records that some template has been loaded.
	always_ff @(posedge clock) begin
		if (rst) begin
			for (int k = 0; k < mfConfigPkg::tapCount; k++) begin
				activeRe[k] <= '0;
				activeIm[k] <= '0;
			end
			activeBank <= 1'b0;
			coeffSetFlag <= 1'b0;
		end else if (loadDone) begin
			activeRe <= shadowRe;
			activeIm <= shadowIm;
			activeBank <= shadowBank;
			coeffSetFlag <= 1'b1;
		end
	end

	// A swap in the same cycle as a sample already applies to that sample.
	always_comb begin
		for (int k = 0; k < mfConfigPkg::tapCount; k++) begin
			useRe[k] = loadDone ? shadowRe[k] : activeRe[k];
			useIm[k] = loadDone ? shadowIm[k] : activeIm[k];
		end
		useBank = loadDone ? shadowBank : activeBank;
		window[0] = sampleIn;
		for (int k = 1; k < mfConfigPkg::tapCount; k++) begin
			window[k] = delayLine[k-1];
		end
	end

	// History starts at zero, so early outputs see zero for missing samples.
	always_ff @(posedge clock) begin
		if (rst) begin
			for (int k = 0; k < mfConfigPkg::tapCount - 1; k++) begin
				delayLine[k] <= '0;
			end
		end else if (sampleStrobe) begin
			for (int k = 0; k < mfConfigPkg::tapCount - 1; k++) begin
				delayLine[k] <= window[k];
			end
		end
	end

	// First stage.
	// The sample is real, so each tap needs only two products.
	always_ff @(posedge clock) begin
		if (sampleStrobe) begin
			for (int k = 0; k < mfConfigPkg::tapCount; k++) begin
				prodRe[k] <= window[k] * useRe[k];
				prodIm[k] <= window[k] * useIm[k];
			end
			prodBank <= useBank;
		end
	end

	// Full-precision sums with sign extension into the guard bits.
	always_comb begin
		sumRe = '0;
		sumIm = '0;
		for (int k = 0; k < mfConfigPkg::tapCount; k++) begin
			sumRe = sumRe + prodRe[k];
			sumIm = sumIm + prodIm[k];
		end
	end

	// Second stage. An output appears two cycles after its sample.
	always_ff @(posedge clock) begin
		if (rst) begin
			prodValid <= 1'b0;
			filtStrobe <= 1'b0;
		end else begin
			prodValid <= sampleStrobe;
			filtStrobe <= prodValid;
		end
	end

	always_ff @(posedge clock) begin
		if (prodValid) begin
			filtRe <= sumRe;
			filtIm <= sumIm;
			filtBank <= prodBank;
		end
	end

endmodule

`default_nettype wire

// ==== logic/mifStreamer.sv ====
// ROM streamer FSM that fetches one ROM region and emits its decoded values as strobed samples.
`timescale 1ns/1ps
`default_nettype none

module mifStreamer #(
	parameter mfWordPkg::streamMode_t mode = mfWordPkg::modeCoeff
) (
	input wire logic clock,
	input wire logic rst,
	input wire logic start,
	input wire logic bankSel,
	output logic romReq,
	output logic [mfConfigPkg::addrWidth-1:0] romAddr,
	input wire logic romGrant,
	input wire mfWordPkg::romWord_t romData,
	output logic outStrobe,
	output logic signed [mfConfigPkg::sampleWidth-1:0] outRe,
	output logic signed [mfConfigPkg::sampleWidth-1:0] outIm,
	output logic done
);

	logic [2:0] state;
	logic [mfConfigPkg::addrWidth-1:0] wordIdx;
	logic [mfConfigPkg::addrWidth-1:0] baseAddr;
	int regionWords;
	// In data mode, low while the earlier half of the word is being sent.
	logic halfSel;
	// Set once the current word has been fully sent.
	logic wordSent;
	mfWordPkg::romWord_t word;

	// Region selection.
	// Only the coefficient streamer looks at bankSel.
	always_comb begin
		if (mode == mfWordPkg::modeData) begin
			baseAddr = mfConfigPkg::dataBase;
			regionWords = mfConfigPkg::dataWords;
		end else begin
			baseAddr = bankSel ? mfConfigPkg::bankBase1 : mfConfigPkg::bankBase0;
			regionWords = mfConfigPkg::tapCount;
		end
	end

	// A coefficient word is done after one strobe.
	// A data word needs two strobes.
	always_comb begin
		wordSent = (mode == mfWordPkg::modeCoeff) || halfSel;
	end

	// The request is a level that holds until the grant arrives.
	always_comb begin
		romReq = (state == mfWordPkg::stRequest);
	end

	always_ff @(posedge clock) begin
		if (rst) begin
			state <= mfWordPkg::stIdle;
			romAddr <= '0;
			wordIdx <= '0;
			halfSel <= 1'b0;
			outStrobe <= 1'b0;
			done <= 1'b0;
		end else begin
			outStrobe <= 1'b0;
			// The load-complete mark is a one-cycle pulse.
			if (mode == mfWordPkg::modeCoeff) begin
				done <= 1'b0;
			end
			case (state)
				mfWordPkg::stIdle: begin
					// A start seen in any other state is dropped.
					if (start) begin
						romAddr <= baseAddr;
						wordIdx <= '0;
						done <= 1'b0;
						state <= mfWordPkg::stRequest;
					end
				end
				mfWordPkg::stRequest: begin
					if (romGrant) begin
						state <= mfWordPkg::stCapture;
					end
				end
				mfWordPkg::stCapture: begin
					halfSel <= 1'b0;
					state <= mfWordPkg::stEmit;
				end
				mfWordPkg::stEmit: begin
					outStrobe <= 1'b1;
					halfSel <= !halfSel;
					if (wordSent) begin
						if (int'(wordIdx) == regionWords - 1) begin
							state <= mfWordPkg::stFinish;
						end else begin
							romAddr <= romAddr + 1'b1;
							wordIdx <= wordIdx + 1'b1;
							state <= mfWordPkg::stRequest;
						end
					end
				end
				mfWordPkg::stFinish: begin
					// Data mode holds done until the next start.
					done <= 1'b1;
					state <= mfWordPkg::stIdle;
				end
				default: state <= mfWordPkg::stIdle;
			endcase
		end
	end

	// The broadcast ROM word is ours only in the cycle after our own grant.
	always_ff @(posedge clock) begin
		if (state == mfWordPkg::stCapture) begin
			word <= romData;
		end
		if (state == mfWordPkg::stEmit) begin
			if (mode == mfWordPkg::modeCoeff) begin
				outRe <= word.coeff[1];
				outIm <= word.coeff[0];
			end else begin
				outRe <= halfSel ? word.samples[0] : word.samples[1];
				outIm <= '0;
			end
		end
	end

endmodule

`default_nettype wire

// ==== romPath/romArbiter.sv ====
// Two-way round-robin arbiter that grants one ROM read per cycle to one of two streamers.
`timescale 1ns/1ps
`default_nettype none

module romArbiter (
	input wire logic clock,
	input wire logic rst,
	input wire logic reqA,
	input wire logic reqB,
	input wire logic [mfConfigPkg::addrWidth-1:0] addrA,
	input wire logic [mfConfigPkg::addrWidth-1:0] addrB,
	output logic grantA,
	output logic grantB,
	output logic [mfConfigPkg::addrWidth-1:0] romAddr
);

	// High when requester B received the most recent grant.
	logic lastB;

	// A lone request is granted at once.
	// When both request, the one not served last wins.
	// The loser waits exactly one cycle.
	// A streamer drops its request after its grant, so each grant lasts one cycle.
	always_comb begin
		grantA = reqA && (!reqB || lastB);
		grantB = reqB && (!reqA || !lastB);
	end

	// The ROM latches this address on the edge that ends the grant cycle.
	// With no grant, the address of A is presented and the read is simply ignored.
	always_comb begin
		if (grantB) begin
			romAddr = addrB;
		end else begin
			romAddr = addrA;
		end
	end

	// Remember who was served.
	// Idle cycles leave the history alone.
	always_ff @(posedge clock) begin
		if (rst) begin
			lastB <= 1'b0;
		end else if (grantA) begin
			lastB <= 1'b0;
		end else if (grantB) begin
			lastB <= 1'b1;
		end
	end

endmodule

`default_nettype wire

// ==== romPath/sampleRom.sv ====
// Shared synchronous-read ROM holding both templates and the input sample block.
`timescale 1ns/1ps
`default_nettype none

module sampleRom (
	input wire logic clock,
	input wire logic [mfConfigPkg::addrWidth-1:0] addr,
	output mfWordPkg::romWord_t data
);

	// The array is kept as plain words.
	// The union view is applied only at the output.
	logic [2*mfConfigPkg::sampleWidth-1:0] mem [mfConfigPkg::romDepth];

	// Contents come from a hex file with one 32-bit word per line.
	// Words 0 to 7 are bank 0, words 8 to 15 are bank 1.
	// The rest is input data.
	initial begin
		$readmemh("mfRom.hex", mem);
	end

	// One read per cycle.
	// The arbiter presents the granted address in the grant cycle.
	// So the word is valid in the cycle after the grant.
	always_ff @(posedge clock) begin
		data <= mem[addr];
	end

endmodule

`default_nettype wire

// ==== common/mfWordPkg.sv ====
// ROM word package with the two decodings of a word and the streamer mode and state codes.
`default_nettype none

package mfWordPkg;

	// One ROM word, read either as a complex coefficient or as two real samples.
	// In the coefficient view, index 1 is the real part and index 0 the imaginary part.
	// In the data view, index 1 is the earlier sample and index 0 the later one.
	typedef union packed {
		logic [1:0][mfConfigPkg::sampleWidth-1:0] coeff;
		logic [1:0][mfConfigPkg::sampleWidth-1:0] samples;
	} romWord_t;

	// A streamer either loads a template or pushes input data.
	typedef enum logic {
		modeCoeff = 1'b0,
		modeData = 1'b1
	} streamMode_t;

	// State codes of the streamer FSM.
	localparam logic [2:0] stIdle = 3'd0;
	localparam logic [2:0] stRequest = 3'd1;
	localparam logic [2:0] stCapture = 3'd2;
	localparam logic [2:0] stEmit = 3'd3;
	localparam logic [2:0] stFinish = 3'd4;

endpackage

`default_nettype wire

// ==== common/mfConfigPkg.sv ====
// Matched-filter configuration package with sizes, counts and the ROM address map.
`default_nettype none

package mfConfigPkg;

	// Width of one real sample and of each half of a complex coefficient.
	localparam int sampleWidth = 16;

	// Number of filter taps. A template holds one ROM word per tap.
	localparam int tapCount = 8;

	// The data region holds two samples per word, so 32 samples in all.
	localparam int dataWords = 16;

	// Total ROM size in words and the address width that covers it.
	localparam int romDepth = 32;
	localparam int addrWidth = $clog2(romDepth);

	// Start addresses of the two templates and of the input data block.
	// Bank 0 and bank 1 each span tapCount words.
	localparam logic [addrWidth-1:0] bankBase0 = addrWidth'(0);
	localparam logic [addrWidth-1:0] bankBase1 = addrWidth'(8);
	localparam logic [addrWidth-1:0] dataBase = addrWidth'(16);

	// A full product is twice the sample width.
	// Three guard bits cover the growth of an eight-term sum.
	localparam int accWidth = 2 * sampleWidth + 3;

endpackage

`default_nettype wire
